// ==== build.f ====
+incdir+.
aesPkg.sv
aesRound.sv
aesCipherCore.sv
ctrKeystream.sv
aesCtrTop.sv
tbClock.sv
aesCtrTb.sv

// ==== Makefile ====
TOP = aesCtrTb

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== aesRefModel.svh ====
// Byte-level AES-128 encryption reference for the keystream testbench
// S-box derived from the field inverse and affine map

`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

    // Multiply in GF(2^8) modulo 0x11b
    function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        logic [7:0] y;
        p = 8'h00;
        x = a;
        y = b;
        for (int i = 0; i < 8; i++) begin
            if (y[0]) begin
                p = p ^ x;
            end
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
            y = y >> 1;
        end
        return p;
    endfunction

    // Inverse as b^254, zero maps to zero
    function automatic logic [7:0] fieldSbox(input logic [7:0] b);
        logic [7:0] inv;
        logic [7:0] sq;
        inv = 8'h01;
        sq  = b;
        for (int k = 1; k < 8; k++) begin
            sq  = gfMul(sq, sq);
            inv = gfMul(inv, sq);
        end
        // Affine map, four left rotations plus 0x63
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
               ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    function automatic logic [blockWidth-1:0] aesEncrypt(input logic [blockWidth-1:0] key,
                                                          input logic [blockWidth-1:0] block);
        logic [7:0]            s [16];
        logic [7:0]            t [16];
        logic [7:0]            rk [176];
        logic [7:0]            w [4];
        logic [7:0]            rc;
        logic [7:0]            a0;
        logic [7:0]            a1;
        logic [7:0]            a2;
        logic [7:0]            a3;
        logic [blockWidth-1:0] result;
        // Byte i at row i%4, column i/4, initial AddRoundKey
        for (int i = 0; i < 16; i++) begin
            rk[i] = key[blockWidth-1-8*i -: 8];
            s[i]  = block[blockWidth-1-8*i -: 8] ^ rk[i];
        end
        // ----------------------------------------
        // Key expansion, 44 words
        // ----------------------------------------
        rc = 8'h01;
        for (int i = 16; i < 176; i += 4) begin
            if (i % 16 == 0) begin
                // RotWord, SubWord, round constant
                w[0] = fieldSbox(rk[i-3]) ^ rc;
                w[1] = fieldSbox(rk[i-2]);
                w[2] = fieldSbox(rk[i-1]);
                w[3] = fieldSbox(rk[i-4]);
                rc   = gfMul(rc, 8'h02);
            end else begin
                for (int k = 0; k < 4; k++) begin
                    w[k] = rk[i-4+k];
                end
            end
            for (int k = 0; k < 4; k++) begin
                rk[i+k] = rk[i-16+k] ^ w[k];
            end
        end
        // ----------------------------------------
        // Rounds
        // ----------------------------------------
        for (int r = 1; r <= numRounds; r++) begin
            // SubBytes, row n rotated left by n
            for (int c = 0; c < 4; c++) begin
                for (int n = 0; n < 4; n++) begin
                    t[4*c+n] = fieldSbox(s[4*((c+n)%4)+n]);
                end
            end
            for (int c = 0; c < 4; c++) begin
                a0 = t[4*c];
                a1 = t[4*c+1];
                a2 = t[4*c+2];
                a3 = t[4*c+3];
                // No MixColumns in the last round
                if (r == numRounds) begin
                    s[4*c]   = a0;
                    s[4*c+1] = a1;
                    s[4*c+2] = a2;
                    s[4*c+3] = a3;
                end else begin
                    s[4*c]   = gfMul(a0, 8'h02) ^ gfMul(a1, 8'h03) ^ a2 ^ a3;
                    s[4*c+1] = a0 ^ gfMul(a1, 8'h02) ^ gfMul(a2, 8'h03) ^ a3;
                    s[4*c+2] = a0 ^ a1 ^ gfMul(a2, 8'h02) ^ gfMul(a3, 8'h03);
                    s[4*c+3] = gfMul(a0, 8'h03) ^ a1 ^ a2 ^ gfMul(a3, 8'h02);
                end
            end
            for (int i = 0; i < 16; i++) begin
                s[i] = s[i] ^ rk[16*r+i];
            end
        end
        for (int i = 0; i < 16; i++) begin
            result[blockWidth-1-8*i -: 8] = s[i];
        end
        return result;
    endfunction

    // Lane j encrypts counter plus j, wrapping in ctrWidth bits
    function automatic keystreamBlock expectedKeystream(input logic [blockWidth-1:0] key,
                                                        input logic [ctrWidth-1:0] ctr);
        keystreamBlock       expKs;
        logic [ctrWidth-1:0] laneCtr;
        for (int j = 0; j < LANES; j++) begin
            laneCtr      = ctr + ctrWidth'(j);
            expKs.lane[j] = aesEncrypt(key, {{(blockWidth - ctrWidth){1'b0}}, laneCtr});
        end
        return expKs;
    endfunction

`endif

// ==== aesCtrTb.sv ====
// Testbench for the AES-128 counter-mode keystream generator
// Scoreboard against a byte-level AES reference, latency and handshake checks

`timescale 1ns/1ps
`default_nettype none

module aesCtrTb import aesPkg::*; ();

    `include "aesRefModel.svh"

    // 1 single, 12 burst, 2 wrap, 10 with gaps
    localparam int numRequests  = 25;
    localparam int timeoutLimit = 40 * numRequests + 100;

    typedef struct packed {
        keystreamBlock expected;
        logic [31:0]   acceptCycle;
    } pendingBlock;

    logic          Clock;
    logic          rstN;
    logic          reqValid;
    ctrRequest     req;
    logic          reqReady;
    logic          ksValid;
    keystreamBlock ks;

    pendingBlock   expectQ [$];
    int            cycleCount;
    int            acceptCount;
    int            outCount;
    logic          sawFull;

    tbClock clockGen (
        .Clock (Clock),
        .rstN  (rstN)
    );

    aesCtrTop DUT (
        .Clock    (Clock),
        .rstN     (rstN),
        .reqValid (reqValid),
        .req      (req),
        .reqReady (reqReady),
        .ksValid  (ksValid),
        .ks       (ks)
    );

    // ----------------------------------------
    // Failure reporting and compare
    // ----------------------------------------
    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic checkValue(input string name, input logic [blockWidth-1:0] actual,
                              input logic [blockWidth-1:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual,
                              expected));
        end
    endtask

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    // Inputs change 1 ns after the rising edge
    task automatic nextCycle();
        @(posedge Clock);
        #1;
    endtask

    // Hold the request until an edge sees reqReady
    task automatic sendRequest(input logic [blockWidth-1:0] key, input logic [ctrWidth-1:0] ctr);
        logic ready;
        reqValid = 1'b1;
        req.key  = key;
        req.ctr  = ctr;
        do begin
            @(negedge Clock);
            ready = reqReady;
            nextCycle();
        end while (!ready);
        reqValid = 1'b0;
    endtask

    // Queue is only popped at falling edges
    task automatic waitDrained();
        while (expectQ.size() != 0) begin
            nextCycle();
        end
    endtask

    function automatic logic [blockWidth-1:0] randomKey();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // ----------------------------------------
    // Cycle counter and timeout
    // ----------------------------------------
    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > timeoutLimit) begin
            failRun($sformatf("Timeout after %0d cycles", cycleCount));
        end
    end

    // ----------------------------------------
    // Scoreboard sampled mid-cycle
    // ----------------------------------------
    always @(negedge Clock) begin
        pendingBlock head;
        pendingBlock entry;
        logic        retiring;
        if (rstN) begin
            // Oldest request due this cycle frees its slot
            retiring = 1'b0;
            if (expectQ.size() != 0) begin
                retiring = (cycleCount - int'(expectQ[0].acceptCycle)) == cipherLatency;
            end
            // Queue size is the number of occupied slots
            checkValue("reqReady", reqReady, (expectQ.size() < SLOTS) || retiring);
            if (!reqReady) begin
                sawFull = 1'b1;
            end
            if (ksValid) begin
                if (expectQ.size() == 0) begin
                    failRun("ksValid raised with no request pending");
                end else begin
                    head = expectQ.pop_front();
                    for (int j = 0; j < LANES; j++) begin
                        checkValue($sformatf("ks.lane[%0d]", j), ks.lane[j],
                                   head.expected.lane[j]);
                    end
                    checkValue("ksValid latency", cycleCount - int'(head.acceptCycle),
                               cipherLatency);
                    outCount++;
                end
            end
            // Accepted at the coming rising edge
            if (reqValid && reqReady) begin
                entry.expected    = expectedKeystream(req.key, req.ctr);
                entry.acceptCycle = cycleCount + 1;
                expectQ.push_back(entry);
                acceptCount++;
            end
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        void'($urandom(3002));
        reqValid    = 1'b0;
        req         = '0;
        cycleCount  = 0;
        acceptCount = 0;
        outCount    = 0;
        sawFull     = 1'b0;

        // Reference against the FIPS-197 example
        checkValue("aesEncrypt", aesEncrypt(128'h000102030405060708090a0b0c0d0e0f,
                   128'h00112233445566778899aabbccddeeff), 128'h69c4e0d86a7b0430d8cdb78070b4c55a);

        wait (rstN === 1'b1);
        // Quiet outputs after reset
        repeat (4) begin
            @(negedge Clock);
            checkValue("ksValid", ksValid, 1'b0);
            checkValue("reqReady", reqReady, 1'b1);
        end
        nextCycle();

        sendRequest(128'h000102030405060708090a0b0c0d0e0f, 64'h0);
        waitDrained();

        // Back-to-back burst, more requests than slots
        repeat (12) begin
            sendRequest(randomKey(), {$urandom, $urandom});
        end
        waitDrained();

        // Lane index pushes the counter past its maximum
        sendRequest(randomKey(), 64'hffff_ffff_ffff_ffff);
        sendRequest(randomKey(), 64'hffff_ffff_ffff_fffe);
        waitDrained();

        // Random idle gaps
        repeat (10) begin
            sendRequest(randomKey(), {$urandom, $urandom});
            repeat ($urandom_range(3)) begin
                nextCycle();
            end
        end
        waitDrained();
        repeat (3) begin
            nextCycle();
        end

        if (expectQ.size() != 0) begin
            failRun("Requests still pending at the end of the run");
        end else if (outCount != acceptCount || acceptCount != numRequests) begin
            failRun($sformatf("Accepted %0d of %0d requests, saw %0d outputs",
                              acceptCount, numRequests, outCount));
        end else if (!sawFull) begin
            failRun("reqReady never fell during the burst");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tbClock.sv ====
// Testbench clock and reset source
// 20 ns clock, active-low reset for two cycles

`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic Clock,
    output logic rstN
);

    // Half period 10 ns
    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    // Release 1 ns after the second rising edge
    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge Clock);
        #1 rstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== aesCtrTop.sv ====
// AES-128 counter-mode keystream generator, top level
// Request in with valid/ready, keystream out as a one-cycle strobe

`timescale 1ns/1ps
`default_nettype none

module aesCtrTop import aesPkg::*; (
    input  logic          Clock,
    input  logic          rstN,
    input  logic          reqValid,
    input  ctrRequest     req,
    output logic          reqReady,
    output logic          ksValid,
    output keystreamBlock ks
);

    // Keystream engine
    ctrKeystream keystream (
        .Clock    (Clock),
        .rstN     (rstN),
        .reqValid (reqValid),
        .req      (req),
        .reqReady (reqReady),
        .ksValid  (ksValid),
        .ks       (ks)
    );

endmodule

`default_nettype wire

// ==== ctrKeystream.sv ====
// Counter-mode keystream engine, SLOTS x LANES AES-128 cores
// Round-robin issue to slots, in-order retire, one block per strobe

`timescale 1ns/1ps
`default_nettype none

module ctrKeystream import aesPkg::*; (
    input  logic          Clock,
    input  logic          rstN,
    input  logic          reqValid,
    input  ctrRequest     req,
    output logic          reqReady,
    output logic          ksValid,
    output keystreamBlock ks
);

    logic [slotIdxWidth-1:0] issueSlot;
    logic [slotIdxWidth-1:0] retireSlot;
    // Needs one extra bit to hold SLOTS
    logic [slotIdxWidth:0]   occupancy;
    logic                    accept;
    logic                    slotsFull;

    logic [SLOTS-1:0]                              slotLoad;
    logic [SLOTS-1:0]                              slotRelease;
    logic [SLOTS-1:0]                              slotDone;
    logic [SLOTS-1:0][LANES-1:0]                   coreDone;
    logic [SLOTS-1:0][LANES-1:0][blockWidth-1:0]   coreText;

    // ----------------------------------------
    // Handshake and retire
    // ----------------------------------------
    assign slotsFull = (occupancy == (slotIdxWidth + 1)'(SLOTS));

    // When full, the retiring slot is also the issue slot and can reload at once
    assign reqReady = !slotsFull || ksValid;
    assign accept   = reqValid && reqReady;

    // All lanes of a slot load together, so they finish together
    assign ksValid  = slotDone[retireSlot];
    assign ks.lane  = coreText[retireSlot];

    // ----------------------------------------
    // Slot pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            issueSlot  <= '0;
            retireSlot <= '0;
            occupancy  <= '0;
        end else begin
            if (accept) begin
                issueSlot <= (issueSlot == slotIdxWidth'(SLOTS - 1)) ?
                             '0 : issueSlot + 1'b1;
            end
            if (ksValid) begin
                retireSlot <= (retireSlot == slotIdxWidth'(SLOTS - 1)) ?
                              '0 : retireSlot + 1'b1;
            end
            // Accept and retire together leave the count alone
            if (accept && !ksValid) begin
                occupancy <= occupancy + 1'b1;
            end else if (!accept && ksValid) begin
                occupancy <= occupancy - 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Core array
    // ----------------------------------------
    for (genvar s = 0; s < SLOTS; s++) begin : gSlot
        assign slotLoad[s]    = accept && (issueSlot == slotIdxWidth'(s));
        assign slotRelease[s] = ksValid && (retireSlot == slotIdxWidth'(s));
        assign slotDone[s]    = &coreDone[s];

        for (genvar j = 0; j < LANES; j++) begin : gLane
            logic [ctrWidth-1:0] laneCtr;

            // Modular add, wraps in ctrWidth bits
            assign laneCtr = req.ctr + ctrWidth'(j);

            aesCipherCore core (
                .Clock       (Clock),
                .rstN        (rstN),
                .load        (slotLoad[s]),
                .key         (req.key),
                .plainText   ({{(blockWidth - ctrWidth){1'b0}}, laneCtr}),
                .releaseCore (slotRelease[s]),
                .done        (coreDone[s][j]),
                .cipherText  (coreText[s][j])
            );
        end
    end

endmodule

`default_nettype wire

// ==== aesCipherCore.sv ====
// Iterative AES-128 encryption core, one round per clock
// Round keys computed on the fly, result held until released

`timescale 1ns/1ps
`default_nettype none

module aesCipherCore import aesPkg::*; (
    input  logic                  Clock,
    input  logic                  rstN,
    input  logic                  load,
    input  logic [blockWidth-1:0] key,
    input  logic [blockWidth-1:0] plainText,
    input  logic                  releaseCore,
    output logic                  done,
    output logic [blockWidth-1:0] cipherText
);

    // 0 idle, 1..10 round in progress, 11 result capture
    logic [3:0]            roundCnt;
    logic                  roundActive;
    logic [blockWidth-1:0] state;
    logic [blockWidth-1:0] roundKey;
    logic [blockWidth-1:0] nextKey;
    logic [blockWidth-1:0] roundOut;
    logic [31:0]           rotWord;
    logic [31:0]           keyTemp;

    assign roundActive = (roundCnt != 4'd0) && (roundCnt <= numRounds);

    // ----------------------------------------
    // Key expansion step
    // ----------------------------------------
    // RotWord of the last key word
    assign rotWord = {roundKey[23:0], roundKey[31:24]};

    // SubWord, then round constant into the top byte
    assign keyTemp = {sbox(rotWord[31:24]), sbox(rotWord[23:16]),
                      sbox(rotWord[15:8]), sbox(rotWord[7:0])}
                     ^ {rcon(roundCnt), 24'h000000};

    // Each new word chains the previous new word
    assign nextKey[127:96] = roundKey[127:96] ^ keyTemp;
    assign nextKey[95:64]  = roundKey[95:64] ^ roundKey[127:96] ^ keyTemp;
    assign nextKey[63:32]  = roundKey[63:32] ^ roundKey[95:64] ^ roundKey[127:96]
                             ^ keyTemp;
    assign nextKey[31:0]   = roundKey[31:0] ^ roundKey[63:32] ^ roundKey[95:64]
                             ^ roundKey[127:96] ^ keyTemp;

    // ----------------------------------------
    // Round datapath
    // ----------------------------------------
    aesRound roundUnit (
        .stateIn   (state),
        .roundKey  (nextKey),
        .lastRound (roundCnt == numRounds),
        .stateOut  (roundOut)
    );

    // Initial AddRoundKey on load, then one round per cycle
    always_ff @(posedge Clock) begin
        if (load) begin
            state    <= plainText ^ key;
            roundKey <= key;
        end else if (roundActive) begin
            state    <= roundOut;
            roundKey <= nextKey;
        end
        // Result register frees the state for the next load
        if (roundCnt == cipherLatency) begin
            cipherText <= state;
        end
    end

    // ----------------------------------------
    // Round counter and done flag
    // ----------------------------------------
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            roundCnt <= 4'd0;
            done     <= 1'b0;
        end else if (load) begin
            // Load wins over a release in the same cycle
            roundCnt <= 4'd1;
            done     <= 1'b0;
        end else if (roundCnt == cipherLatency) begin
            roundCnt <= 4'd0;
            done     <= 1'b1;
        end else begin
            if (roundCnt != 4'd0) begin
                roundCnt <= roundCnt + 4'd1;
            end
            if (releaseCore) begin
                done <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== aesRound.sv ====
// AES encryption round, purely combinational
// SubBytes, ShiftRows, MixColumns unless last round, AddRoundKey

`timescale 1ns/1ps
`default_nettype none

module aesRound import aesPkg::*; (
    input  logic [blockWidth-1:0] stateIn,
    input  logic [blockWidth-1:0] roundKey,
    input  logic                  lastRound,
    output logic [blockWidth-1:0] stateOut
);

    // Byte i of the state sits at row i%4, column i/4
    logic [7:0]            shifted [16];
    logic [blockWidth-1:0] mixed;

    // One column through the fixed MixColumns matrix
    function automatic logic [31:0] mixColumn(input logic [31:0] col);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        // 2 3 1 1 circulant
        mixColumn[31:24] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
        mixColumn[23:16] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
        mixColumn[15:8]  = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
        mixColumn[7:0]   = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
    endfunction

    // ----------------------------------------
    // SubBytes and ShiftRows
    // ----------------------------------------
    always_comb begin
        int src;
        for (int i = 0; i < 16; i++) begin
            // Row r takes its byte from column (c + r) mod 4
            src = (i % 4) + 4 * (((i / 4) + (i % 4)) % 4);
            shifted[i] = sbox(stateIn[blockWidth - 1 - 8 * src -: 8]);
        end
    end

    // ----------------------------------------
    // MixColumns, skipped in round ten
    // ----------------------------------------
    always_comb begin
        logic [31:0] column;
        for (int c = 0; c < 4; c++) begin
            column = {shifted[4*c], shifted[4*c+1], shifted[4*c+2], shifted[4*c+3]};
            mixed[blockWidth - 1 - 32 * c -: 32] = lastRound ? column : mixColumn(column);
        end
    end

    // AddRoundKey
    assign stateOut = mixed ^ roundKey;

endmodule

`default_nettype wire

// ==== aesPkg.sv ====
// AES-128 counter-mode keystream package
// Sizes, request and keystream structs, S-box and round constants

`default_nettype none

package aesPkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int blockWidth    = 128;
    localparam int ctrWidth      = 64;
    localparam int LANES         = 2;
    localparam int SLOTS         = 4;
    localparam int slotIdxWidth  = $clog2(SLOTS);
    localparam int numRounds     = 10;
    // Load edge to done, one extra cycle for the result register
    localparam int cipherLatency = numRounds + 1;

    // ----------------------------------------
    // Request and result types
    // ----------------------------------------
    typedef struct packed {
        logic [blockWidth-1:0] key;
        logic [ctrWidth-1:0]   ctr;
    } ctrRequest;

    // Lane 0 in the low bits
    typedef struct packed {
        logic [LANES-1:0][blockWidth-1:0] lane;
    } keystreamBlock;

    // ----------------------------------------
    // Forward S-box
    // ----------------------------------------
    localparam logic [7:0] sboxTable [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    function automatic logic [7:0] sbox(input logic [7:0] b);
        return sboxTable[b];
    endfunction

    // Multiply by x in GF(2^8), reduction polynomial 0x11b
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Key schedule round constant, rounds 1 to 10
    function automatic logic [7:0] rcon(input logic [3:0] round);
        case (round)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

endpackage

`default_nettype wire
